//--- rtl/nbdcache_pkg.sv
// Cache geometry, address field types and controller states for the L1 data cache
`default_nettype none

package nbdcache_pkg;

    // --------------------
    // Geometry
    // --------------------
    localparam int unsigned N_PORTS        = 2;
    localparam int unsigned ADDR_W         = 32;
    localparam int unsigned WORD_W         = 32;
    localparam int unsigned WORDS_PER_LINE = 4;

    // Byte offset within a line, then set index, tag on top
    localparam int unsigned OFFSET_W       = 4;
    localparam int unsigned INDEX_W        = 6;
    localparam int unsigned TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
    localparam int unsigned NUM_SETS       = 1 << INDEX_W;

    // --------------------
    // Types
    // --------------------
    typedef logic [ADDR_W-1:0]                addr_t;
    typedef logic [WORD_W-1:0]                word_t;
    typedef logic [WORDS_PER_LINE*WORD_W-1:0] line_t;
    typedef logic [TAG_W-1:0]                 tag_t;
    typedef logic [INDEX_W-1:0]               index_t;

    // Word within a line, taken from the upper offset bits
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

    // One bit per load port
    typedef logic [N_PORTS-1:0]               port_sel_t;

    // Per-port load controller
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS_WAIT,
        REPLAY
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- rtl/nbdcache_arrays.sv
// Direct-mapped tag, valid and line storage with registered single-cycle reads
`default_nettype none

module nbdcache_arrays
    import nbdcache_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_ni,
    // Read port
    input  logic   rd_en_i,
    input  index_t rd_index_i,
    output logic   rd_valid_o,
    output tag_t   rd_tag_o,
    output line_t  rd_line_o,
    // Refill write port
    input  logic   wr_en_i,
    input  index_t wr_index_i,
    input  tag_t   wr_tag_i,
    input  line_t  wr_line_i
);

    tag_t                tag_mem  [NUM_SETS];
    line_t               line_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    // Valid bits, cleared on reset and set by each refill
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            if (wr_en_i) begin
                valid_q[wr_index_i] <= 1'b1;
            end
            if (rd_en_i) begin
                rd_valid_o <= valid_q[rd_index_i];
            end
        end
    end

    // Tag and line storage
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_mem[wr_index_i]  <= wr_tag_i;
            line_mem[wr_index_i] <= wr_line_i;
        end
        if (rd_en_i) begin
            rd_tag_o  <= tag_mem[rd_index_i];
            rd_line_o <= line_mem[rd_index_i];
        end
    end

endmodule

`default_nettype wire

//--- rtl/nbdcache_tag_cmp.sv
// Round-robin lookup arbiter onto the arrays with tag compare and word select
`default_nettype none

module nbdcache_tag_cmp
    import nbdcache_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_ni,
    // Lookups from the port controllers
    input  port_sel_t           lk_req_i,
    output port_sel_t           lk_gnt_o,
    input  addr_t [N_PORTS-1:0] lk_addr_i,
    output logic                lk_hit_o,
    output word_t               lk_word_o,
    // Refill write from the miss handler
    input  logic                miss_wr_en_i,
    input  index_t              miss_wr_index_i,
    input  tag_t                miss_wr_tag_i,
    input  line_t               miss_wr_line_i,
    // Arrays
    output logic                rd_en_o,
    output index_t              rd_index_o,
    input  logic                rd_valid_i,
    input  tag_t                rd_tag_i,
    input  line_t               rd_line_i,
    output logic                wr_en_o,
    output index_t              wr_index_o,
    output tag_t                wr_tag_o,
    output line_t               wr_line_o
);

    typedef logic [$clog2(N_PORTS)-1:0] port_idx_t;

    port_idx_t rr_q;
    port_idx_t sel_idx;
    logic      sel_valid;
    logic      look_q;
    tag_t      tag_q;
    word_sel_t wsel_q;

    // --------------------
    // Arbitration
    // --------------------
    // First requester at or after the pointer wins
    always_comb begin
        int cand;
        sel_idx   = rr_q;
        sel_valid = 1'b0;
        for (int k = N_PORTS - 1; k >= 0; k--) begin
            cand = (int'(rr_q) + k) % N_PORTS;
            if (lk_req_i[cand]) begin
                sel_idx   = port_idx_t'(cand);
                sel_valid = 1'b1;
            end
        end
        // Refill write owns the arrays this cycle
        if (miss_wr_en_i) begin
            sel_valid = 1'b0;
        end
    end

    always_comb begin
        lk_gnt_o = '0;
        if (sel_valid) begin
            lk_gnt_o[sel_idx] = 1'b1;
        end
    end

    assign rd_en_o    = sel_valid;
    assign rd_index_o = lk_addr_i[sel_idx][OFFSET_W +: INDEX_W];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q   <= '0;
            look_q <= 1'b0;
        end else begin
            look_q <= sel_valid;
            if (sel_valid) begin
                rr_q <= port_idx_t'((int'(sel_idx) + 1) % N_PORTS);
            end
        end
    end

    // --------------------
    // Compare stage
    // --------------------
    always_ff @(posedge clk_i) begin
        if (sel_valid) begin
            tag_q  <= lk_addr_i[sel_idx][ADDR_W-1 -: TAG_W];
            wsel_q <= lk_addr_i[sel_idx][OFFSET_W-1 -: $bits(word_sel_t)];
        end
    end

    // Only the port granted last cycle is listening
    assign lk_hit_o  = look_q & rd_valid_i & (rd_tag_i == tag_q);
    assign lk_word_o = rd_line_i[wsel_q*WORD_W +: WORD_W];

    assign wr_en_o    = miss_wr_en_i;
    assign wr_index_o = miss_wr_index_i;
    assign wr_tag_o   = miss_wr_tag_i;
    assign wr_line_o  = miss_wr_line_i;

endmodule

`default_nettype wire

//--- rtl/nbdcache_port_ctrl.sv
// Per-port load controller with lookup, hit return, miss request and replay
`default_nettype none

module nbdcache_port_ctrl
    import nbdcache_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,
    // Core load port
    input  logic  req_i,
    input  addr_t addr_i,
    output logic  gnt_o,
    output logic  rvalid_o,
    output word_t rdata_o,
    // Lookup through tag compare
    output logic  lk_req_o,
    output addr_t lk_addr_o,
    input  logic  lk_gnt_i,
    input  logic  lk_hit_i,
    input  word_t lk_word_i,
    // Miss handler
    output logic  miss_req_o,
    output addr_t miss_addr_o,
    input  logic  miss_gnt_i,
    input  logic  refill_done_i
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    addr_t       addr_q;
    logic        miss_pend_q;

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_d  = state_q;
        lk_req_o = 1'b0;
        gnt_o    = 1'b0;
        rvalid_o = 1'b0;
        unique case (state_q)
            IDLE: begin
                lk_req_o = req_i;
                // Core sees its grant only on the first lookup
                if (req_i && lk_gnt_i) begin
                    gnt_o   = 1'b1;
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lk_hit_i) begin
                    rvalid_o = 1'b1;
                    state_d  = IDLE;
                end else begin
                    state_d = MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                if (refill_done_i) begin
                    state_d = REPLAY;
                end
            end
            REPLAY: begin
                // Line may have been evicted again, so this can miss too
                lk_req_o = 1'b1;
                if (lk_gnt_i) begin
                    state_d = LOOKUP;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            miss_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == LOOKUP && !lk_hit_i) begin
                miss_pend_q <= 1'b1;
            end else if (miss_gnt_i) begin
                miss_pend_q <= 1'b0;
            end
        end
    end

    // Request address, kept for replays
    always_ff @(posedge clk_i) begin
        if (gnt_o) begin
            addr_q <= addr_i;
        end
    end

    assign lk_addr_o   = (state_q == IDLE) ? addr_i : addr_q;
    assign miss_req_o  = miss_pend_q;
    assign miss_addr_o = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign rdata_o     = lk_word_i;

endmodule

`default_nettype wire

//--- rtl/nbdcache_miss_handler.sv
// Miss handler serving one line refill at a time from next-level memory
`default_nettype none

module nbdcache_miss_handler
    import nbdcache_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_ni,
    // Port controllers
    input  port_sel_t           miss_req_i,
    input  addr_t [N_PORTS-1:0] miss_addr_i,
    output port_sel_t           miss_gnt_o,
    output port_sel_t           refill_done_o,
    output logic                miss_o,
    // Next-level memory
    output logic                mem_req_o,
    output addr_t               mem_addr_o,
    input  logic                mem_gnt_i,
    input  logic                mem_rvalid_i,
    input  word_t               mem_rdata_i,
    // Refill write towards the arrays
    output logic                wr_en_o,
    output index_t              wr_index_o,
    output tag_t                wr_tag_o,
    output line_t               wr_line_o
);

    typedef enum logic [1:0] {
        MH_IDLE,
        MH_REQ,
        MH_FILL,
        MH_WRITE
    } mh_state_e;

    mh_state_e state_q;
    port_sel_t pick;
    addr_t     pick_addr;
    port_sel_t port_q;
    addr_t     addr_q;
    line_t     line_q;
    word_sel_t beat_q;

    // Lowest requesting port wins
    always_comb begin
        pick      = '0;
        pick_addr = miss_addr_i[0];
        for (int p = N_PORTS - 1; p >= 0; p--) begin
            if (miss_req_i[p]) begin
                pick      = '0;
                pick[p]   = 1'b1;
                pick_addr = miss_addr_i[p];
            end
        end
    end

    assign miss_gnt_o = (state_q == MH_IDLE) ? pick : '0;
    assign miss_o     = (state_q == MH_IDLE) && (|miss_req_i);

    // --------------------
    // Refill sequence
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= MH_IDLE;
            port_q  <= '0;
            beat_q  <= '0;
        end else begin
            unique case (state_q)
                MH_IDLE: begin
                    if (|miss_req_i) begin
                        port_q  <= pick;
                        state_q <= MH_REQ;
                    end
                end
                MH_REQ: begin
                    if (mem_gnt_i) begin
                        beat_q  <= '0;
                        state_q <= MH_FILL;
                    end
                end
                MH_FILL: begin
                    if (mem_rvalid_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == word_sel_t'(WORDS_PER_LINE - 1)) begin
                            state_q <= MH_WRITE;
                        end
                    end
                end
                default: begin
                    state_q <= MH_IDLE;
                end
            endcase
        end
    end

    // Line buffer, beats arrive in word order
    always_ff @(posedge clk_i) begin
        if (state_q == MH_IDLE && (|miss_req_i)) begin
            addr_q <= pick_addr;
        end
        if (state_q == MH_FILL && mem_rvalid_i) begin
            line_q[beat_q*WORD_W +: WORD_W] <= mem_rdata_i;
        end
    end

    assign mem_req_o  = (state_q == MH_REQ);
    assign mem_addr_o = addr_q;

    assign wr_en_o       = (state_q == MH_WRITE);
    assign wr_index_o    = addr_q[OFFSET_W +: INDEX_W];
    assign wr_tag_o      = addr_q[ADDR_W-1 -: TAG_W];
    assign wr_line_o     = line_q;
    assign refill_done_o = wr_en_o ? port_q : '0;

endmodule

`default_nettype wire

//--- rtl/nbdcache_top.sv
// Non-blocking read-only L1 data cache top with per-port controllers
`default_nettype none

module nbdcache_top
    import nbdcache_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_ni,
    // Load ports
    input  port_sel_t           req_i,
    input  addr_t [N_PORTS-1:0] addr_i,
    output port_sel_t           gnt_o,
    output port_sel_t           rvalid_o,
    output word_t [N_PORTS-1:0] rdata_o,
    output logic                miss_o,
    // Next-level memory
    output logic                mem_req_o,
    output addr_t               mem_addr_o,
    input  logic                mem_gnt_i,
    input  logic                mem_rvalid_i,
    input  word_t               mem_rdata_i
);

    // Controllers <-> tag compare
    port_sel_t           lk_req;
    port_sel_t           lk_gnt;
    addr_t [N_PORTS-1:0] lk_addr;
    logic                lk_hit;
    word_t               lk_word;

    // Controllers <-> miss handler
    port_sel_t           miss_req;
    addr_t [N_PORTS-1:0] miss_addr;
    port_sel_t           miss_gnt;
    port_sel_t           refill_done;

    // Miss handler -> tag compare
    logic                mh_wr_en;
    index_t              mh_wr_index;
    tag_t                mh_wr_tag;
    line_t               mh_wr_line;

    // Tag compare <-> arrays
    logic                rd_en;
    index_t              rd_index;
    logic                rd_valid;
    tag_t                rd_tag;
    line_t               rd_line;
    logic                arr_wr_en;
    index_t              arr_wr_index;
    tag_t                arr_wr_tag;
    line_t               arr_wr_line;

    // --------------------
    // Port controllers
    // --------------------
    for (genvar i = 0; i < N_PORTS; i++) begin : gen_port
        nbdcache_port_ctrl nbdcache_port_ctrl_inst (
            .clk_i         (clk_i),
            .rst_ni        (rst_ni),
            .req_i         (req_i[i]),
            .addr_i        (addr_i[i]),
            .gnt_o         (gnt_o[i]),
            .rvalid_o      (rvalid_o[i]),
            .rdata_o       (rdata_o[i]),
            .lk_req_o      (lk_req[i]),
            .lk_addr_o     (lk_addr[i]),
            .lk_gnt_i      (lk_gnt[i]),
            .lk_hit_i      (lk_hit),
            .lk_word_i     (lk_word),
            .miss_req_o    (miss_req[i]),
            .miss_addr_o   (miss_addr[i]),
            .miss_gnt_i    (miss_gnt[i]),
            .refill_done_i (refill_done[i])
        );
    end

    nbdcache_miss_handler nbdcache_miss_handler_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .miss_req_i    (miss_req),
        .miss_addr_i   (miss_addr),
        .miss_gnt_o    (miss_gnt),
        .refill_done_o (refill_done),
        .miss_o        (miss_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_gnt_i     (mem_gnt_i),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rdata_i   (mem_rdata_i),
        .wr_en_o       (mh_wr_en),
        .wr_index_o    (mh_wr_index),
        .wr_tag_o      (mh_wr_tag),
        .wr_line_o     (mh_wr_line)
    );

    // --------------------
    // Arbitration and storage
    // --------------------
    nbdcache_tag_cmp nbdcache_tag_cmp_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .lk_req_i        (lk_req),
        .lk_gnt_o        (lk_gnt),
        .lk_addr_i       (lk_addr),
        .lk_hit_o        (lk_hit),
        .lk_word_o       (lk_word),
        .miss_wr_en_i    (mh_wr_en),
        .miss_wr_index_i (mh_wr_index),
        .miss_wr_tag_i   (mh_wr_tag),
        .miss_wr_line_i  (mh_wr_line),
        .rd_en_o         (rd_en),
        .rd_index_o      (rd_index),
        .rd_valid_i      (rd_valid),
        .rd_tag_i        (rd_tag),
        .rd_line_i       (rd_line),
        .wr_en_o         (arr_wr_en),
        .wr_index_o      (arr_wr_index),
        .wr_tag_o        (arr_wr_tag),
        .wr_line_o       (arr_wr_line)
    );

    nbdcache_arrays nbdcache_arrays_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rd_en_i    (rd_en),
        .rd_index_i (rd_index),
        .rd_valid_o (rd_valid),
        .rd_tag_o   (rd_tag),
        .rd_line_o  (rd_line),
        .wr_en_i    (arr_wr_en),
        .wr_index_i (arr_wr_index),
        .wr_tag_i   (arr_wr_tag),
        .wr_line_i  (arr_wr_line)
    );

endmodule

`default_nettype wire

//--- verification/nbdcache_mem.sv
// Next-level memory model returning address-derived words after a random grant delay
`default_nettype none

module nbdcache_mem
    import nbdcache_pkg::*;
(
    input  wire   clk_i,
    input  wire   rst_ni,
    input  wire   mem_req_i,
    input  addr_t mem_addr_i,
    output logic  mem_gnt_o,
    output logic  mem_rvalid_o,
    output word_t mem_rdata_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] rng;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Word data is the xorshift of the word address
    function automatic word_t word_data(input addr_t a);
        return xorshift(a >> 2);
    endfunction

    task automatic serve_line();
        addr_t base;
        int    wait_cycles;
        rng = xorshift(rng);
        wait_cycles = int'(rng % 4);
        repeat (wait_cycles) @(posedge clk_i);
        #1;
        mem_gnt_o = 1'b1;
        base      = mem_addr_i;
        @(posedge clk_i);
        #1;
        mem_gnt_o = 1'b0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            mem_rvalid_o = 1'b0;
            // Optional gap before each beat
            rng = xorshift(rng);
            repeat (int'(rng % 2)) begin
                @(posedge clk_i);
                #1;
            end
            mem_rvalid_o = 1'b1;
            mem_rdata_o  = word_data(base + addr_t'(w * 4));
            @(posedge clk_i);
            #1;
        end
        mem_rvalid_o = 1'b0;
    endtask

    initial begin
        mem_gnt_o    = 1'b0;
        mem_rvalid_o = 1'b0;
        mem_rdata_o  = '0;
        rng          = 32'h35d68026;
        forever begin
            @(posedge clk_i);
            if (rst_ni && mem_req_i) begin
                serve_line();
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/nbdcache_tb.sv
// Testbench for the L1 data cache with a reference data rule and concurrent checks
`default_nettype none

module nbdcache_tb
    import nbdcache_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_REQ = 11;

    logic                clk_i = 1'b0;
    logic                rst_ni;
    port_sel_t           req_i;
    addr_t [N_PORTS-1:0] addr_i;
    port_sel_t           gnt_o;
    port_sel_t           rvalid_o;
    word_t [N_PORTS-1:0] rdata_o;
    logic                miss_o;
    logic                mem_req_o;
    addr_t               mem_addr_o;
    logic                mem_gnt_i;
    logic                mem_rvalid_i;
    word_t               mem_rdata_i;

    // Monitor state
    addr_t               pend_addr [N_PORTS];
    port_sel_t           exp_hit = '0;
    port_sel_t           gnt_d   = '0;
    port_sel_t           hit_d   = '0;
    port_sel_t           busy    = '0;
    int                  miss_cnt = 0;
    int                  errors = 0;
    int                  err_start = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    bit                  overlap = 1'b0;
    string               cur_test = "none";

    always #2 clk_i = ~clk_i;

    nbdcache_top nbdcache_top_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .gnt_o        (gnt_o),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o),
        .miss_o       (miss_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    nbdcache_mem nbdcache_mem_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .mem_req_i    (mem_req_o),
        .mem_addr_i   (mem_addr_o),
        .mem_gnt_o    (mem_gnt_i),
        .mem_rvalid_o (mem_rvalid_i),
        .mem_rdata_o  (mem_rdata_i)
    );

    // Memory data rule is the xorshift of the word address
    function automatic word_t expected_word(input addr_t a);
        logic [31:0] y;
        y = a >> 2;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Refill address must be the aligned line of a load still in flight
    function automatic bit refill_line_pending(input addr_t a);
        bit    found;
        addr_t line_mask;
        found     = 1'b0;
        line_mask = ~addr_t'(WORDS_PER_LINE * 4 - 1);
        for (int p = 0; p < N_PORTS; p++) begin
            if (busy[p] && a == (pend_addr[p] & line_mask)) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // --------------------
    // Monitor
    // --------------------
    always @(posedge clk_i) begin
        for (int p = 0; p < N_PORTS; p++) begin
            if (gnt_o[p]) begin
                pend_addr[p] <= addr_i[p];
                busy[p]      <= 1'b1;
            end else if (rvalid_o[p]) begin
                busy[p] <= 1'b0;
            end
        end
        gnt_d <= gnt_o;
        hit_d <= exp_hit;
    end

    always @(negedge clk_i) begin
        if (rst_ni && miss_o) begin
            miss_cnt++;
        end
        if (rvalid_o[1] && busy[0]) begin
            overlap = 1'b1;
        end
    end

    // --------------------
    // Checks
    // --------------------
    for (genvar g = 0; g < N_PORTS; g++) begin : gen_chk
        assert property (@(negedge clk_i)
            rvalid_o[g] |-> rdata_o[g] == expected_word(pend_addr[g]))
        else begin
            $display("Fail %s: port %0d data expected %h, actual %h", cur_test, g,
                     expected_word(pend_addr[g]), rdata_o[g]);
            errors++;
        end

        // A hit returns one cycle after the grant
        assert property (@(negedge clk_i) (gnt_d[g] && hit_d[g]) |-> rvalid_o[g])
        else begin
            $display("Fail %s: port %0d rvalid after grant expected 1, actual %b",
                     cur_test, g, rvalid_o[g]);
            errors++;
        end
    end

    assert property (@(negedge clk_i) mem_req_o |-> refill_line_pending(mem_addr_o))
    else begin
        $display("Fail %s: refill address expected line of a pending load, actual %h",
                 cur_test, mem_addr_o);
        errors++;
    end

    assert property (@(negedge clk_i)
        !rst_ni |-> (gnt_o == '0 && rvalid_o == '0 && !miss_o && !mem_req_o))
    else begin
        $display("Fail %s: outputs in reset expected 0, actual %b",
                 cur_test, {gnt_o, rvalid_o, miss_o, mem_req_o});
        errors++;
    end

    // --------------------
    // Driver and test bookkeeping
    // --------------------
    task automatic load(input int p, input addr_t a, input bit hit);
        exp_hit[p] = hit;
        req_i[p]   = 1'b1;
        addr_i[p]  = a;
        do @(negedge clk_i); while (!gnt_o[p]);
        @(posedge clk_i);
        #1;
        req_i[p] = 1'b0;
        while (!rvalid_o[p]) @(negedge clk_i);
        @(posedge clk_i);
        #1;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        miss_cnt  = 0;
        err_start = errors;
    endtask

    task automatic end_test(input int exp_misses);
        assert (miss_cnt == exp_misses)
        else begin
            $display("Fail %s: miss_o pulses expected %0d, actual %0d",
                     cur_test, exp_misses, miss_cnt);
            errors++;
        end
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("%s: %s", cur_test, (errors == err_start) ? "ok" : "failed");
    endtask

    initial begin
        rst_ni = 1'b0;
        req_i  = '0;
        addr_i = '0;
        start_test("reset");
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        load(0, 32'h0000_0100, 1'b0);
        end_test(1);

        start_test("miss_then_hit");
        load(0, 32'h0000_0180, 1'b0);
        load(0, 32'h0000_018c, 1'b1);
        end_test(1);

        start_test("two_ports");
        fork
            load(0, 32'h0000_0300, 1'b0);
            load(1, 32'h0000_0340, 1'b0);
        join
        overlap = 1'b0;
        fork
            load(0, 32'h0000_0380, 1'b0);
            begin
                repeat (2) @(posedge clk_i);
                #1;
                load(1, 32'h0000_0344, 1'b1);
            end
        join
        assert (overlap)
        else begin
            $display("two_ports: port 1 did not return while port 0 waited for a refill");
            errors++;
        end
        end_test(3);

        // Same set index with different tags
        start_test("conflict_eviction");
        load(0, 32'h0000_0200, 1'b0);
        load(0, 32'h0000_4200, 1'b0);
        load(0, 32'h0000_0204, 1'b0);
        load(0, 32'h0000_4208, 1'b0);
        end_test(4);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (8 + 200 * N_REQ) @(posedge clk_i);
        $display("Timeout: run did not finish within %0d cycles", 8 + 200 * N_REQ);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- nbdcache.f
rtl/nbdcache_pkg.sv
rtl/nbdcache_arrays.sv
rtl/nbdcache_tag_cmp.sv
rtl/nbdcache_port_ctrl.sv
rtl/nbdcache_miss_handler.sv
rtl/nbdcache_top.sv
verification/nbdcache_mem.sv
verification/nbdcache_tb.sv

//--- Makefile
SRCS := $(wildcard rtl/*.sv verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vnbdcache_tb: $(SRCS) nbdcache.f
	verilator --binary --timing --assert -f nbdcache.f --top-module nbdcache_tb -o Vnbdcache_tb

run: obj_dir/Vnbdcache_tb
	./obj_dir/Vnbdcache_tb | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
